// File: project.f
lce_cmd_pkg.sv
lce_cmd_ctrl.sv
lce_mem_pkt_gen.sv
lce_resp_gen.sv
lce_tr_buffer.sv
lce_cmd_top.sv
lce_cmd_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module lce_cmd_tb -f project.f -o lce_cmd_sim
	./obj_dir/lce_cmd_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: lce_cmd_tb.sv
/*
  LCE command side testbench
  Sends directory commands to the agent and answers the tag, metadata
  and data memories with random stalls. Every accepted request,
  response and transfer is compared with reference functions.
*/

`timescale 1ns/1ps

module lce_cmd_tb import lce_cmd_pkg::*; ();

  // 17 commands, each under about 60 cycles with 50% stalls
  localparam int max_cycles_lp = 3000;
  localparam logic [lce_id_width_lp-1:0] own_id_lp = 2'd1;

  logic clk_i, reset_i, lce_ready_o, tag_set_o, tag_set_wakeup_o;
  logic [lce_id_width_lp-1:0] id_i, cmd_target_i, resp_src_id_o, tr_dst_id_o, tr_src_id_o;
  logic cmd_v_i, cmd_yumi_o;
  cmd_msg_e cmd_msg_type_i;
  logic [cce_id_width_lp-1:0] cmd_src_id_i, resp_dst_id_o;
  logic [addr_width_lp-1:0] cmd_addr_i, resp_addr_o, tr_addr_o;
  logic [way_width_lp-1:0] cmd_way_id_i, cmd_target_way_id_i, tag_mem_way_o, meta_mem_way_o;
  logic [way_width_lp-1:0] data_mem_way_o, tr_way_id_o;
  coh_state_e cmd_state_i, tag_mem_state_o;
  logic tag_mem_v_o, tag_mem_yumi_i, meta_mem_v_o, meta_mem_yumi_i;
  logic data_mem_v_o, data_mem_yumi_i, resp_v_o, resp_yumi_i, tr_v_o, tr_ready_i;
  logic [index_width_lp-1:0] tag_mem_index_o, meta_mem_index_o, data_mem_index_o;
  logic [tag_width_lp-1:0] tag_mem_tag_o;
  tag_op_e tag_mem_opcode_o;
  meta_op_e meta_mem_opcode_o;
  resp_msg_e resp_msg_type_o;
  logic [data_width_lp-1:0] data_mem_data_i, tr_data_o;

  logic tag_rdy, meta_rdy, data_rdy, resp_rdy, stall_en, ready_exp, tr_open;
  string test_name;
  int errors, err_at_start, checks, tests;
  int cycles = 0;
  int tag_cnt, meta_cnt, resp_cnt, tr_cnt, set_cnt, wake_cnt, sync_cnt;

  lce_cmd_top lce_cmd_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // memories and directory take a request only while it is offered
  assign tag_mem_yumi_i  = tag_mem_v_o & tag_rdy;
  assign meta_mem_yumi_i = meta_mem_v_o & meta_rdy;
  assign data_mem_yumi_i = data_mem_v_o & data_rdy;
  assign resp_yumi_i     = resp_v_o & resp_rdy;

  function automatic logic [index_width_lp-1:0] index_of(input logic [addr_width_lp-1:0] addr);
    return index_width_lp'(addr >> offset_width_lp);
  endfunction

  function automatic logic [tag_width_lp-1:0] tag_field(input cmd_msg_e msg,
                                                        input logic [addr_width_lp-1:0] addr);
    if (msg == e_cmd_set_clear) begin
      return '0;
    end
    return tag_width_lp'(addr >> (offset_width_lp + index_width_lp));
  endfunction

  function automatic coh_state_e state_field(input cmd_msg_e msg, input coh_state_e state);
    return (msg == e_cmd_set_clear || msg == e_cmd_invalidate_tag) ? e_coh_i : state;
  endfunction

  function automatic tag_op_e tag_opcode(input cmd_msg_e msg);
    case (msg)
      e_cmd_set_clear:      return e_tag_set_clear;
      e_cmd_invalidate_tag: return e_tag_invalidate;
      default:              return e_tag_set_tag;
    endcase
  endfunction

  function automatic meta_op_e meta_opcode(input cmd_msg_e msg);
    return (msg == e_cmd_set_clear) ? e_meta_set_clear : e_meta_set_lru;
  endfunction

  function automatic resp_msg_e ack_type(input cmd_msg_e msg);
    return (msg == e_cmd_sync) ? e_resp_sync_ack : e_resp_inv_ack;
  endfunction

  function automatic logic [addr_width_lp-1:0] ack_addr(input cmd_msg_e msg,
                                                        input logic [addr_width_lp-1:0] addr);
    return (msg == e_cmd_sync) ? '0 : addr;
  endfunction

  // data memory contents, a hash of index and way
  function automatic logic [data_width_lp-1:0] block_at(input logic [index_width_lp-1:0] index,
                                                        input logic [way_width_lp-1:0] way);
    logic [data_width_lp-1:0] key;
    key = data_width_lp'({index, way});
    return (key * 64'h9e37_79b9_7f4a_7c15) ^ 64'h0f1e_2d3c_4b5a_6978;
  endfunction

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  // random stalls, read block valid only in the cycle after yumi
  always @(posedge clk_i) begin
    tag_rdy    <= stall_en ? 1'($urandom % 2) : 1'b1;
    meta_rdy   <= stall_en ? 1'($urandom % 2) : 1'b1;
    data_rdy   <= stall_en ? 1'($urandom % 2) : 1'b1;
    resp_rdy   <= stall_en ? 1'($urandom % 2) : 1'b1;
    tr_ready_i <= stall_en ? ($urandom % 4 == 0) : 1'b1;
    if (data_mem_v_o & data_mem_yumi_i) begin
      data_mem_data_i <= block_at(data_mem_index_o, data_mem_way_o);
    end else begin
      data_mem_data_i <= {$urandom, $urandom};
    end
  end

  // compares every accepted request against the current command
  always @(posedge clk_i) begin
    if (!reset_i) begin
      check("lce_ready", ready_exp, lce_ready_o);
      if (tag_mem_v_o & tag_mem_yumi_i) begin
        tag_cnt++;
        check("tag opcode", tag_opcode(cmd_msg_type_i), tag_mem_opcode_o);
        check("tag index", index_of(cmd_addr_i), tag_mem_index_o);
        check("tag way", cmd_way_id_i, tag_mem_way_o);
        check("tag state", state_field(cmd_msg_type_i, cmd_state_i), tag_mem_state_o);
        check("tag value", tag_field(cmd_msg_type_i, cmd_addr_i), tag_mem_tag_o);
      end
      if (meta_mem_v_o & meta_mem_yumi_i) begin
        meta_cnt++;
        check("meta opcode", meta_opcode(cmd_msg_type_i), meta_mem_opcode_o);
        check("meta index", index_of(cmd_addr_i), meta_mem_index_o);
        check("meta way", cmd_way_id_i, meta_mem_way_o);
        check("meta after tag", 1, tag_cnt > 0);
      end
      if (resp_v_o & resp_yumi_i) begin
        resp_cnt++;
        check("resp type", ack_type(cmd_msg_type_i), resp_msg_type_o);
        check("resp dst", cmd_src_id_i, resp_dst_id_o);
        check("resp src", id_i, resp_src_id_o);
        check("resp addr", ack_addr(cmd_msg_type_i, cmd_addr_i), resp_addr_o);
        if (cmd_msg_type_i == e_cmd_sync) begin
          sync_cnt++;
          ready_exp = (sync_cnt >= num_cce_lp);
        end else begin
          check("ack after both writes", 1, tag_cnt == 1 && meta_cnt == 1);
        end
      end
      if (cmd_v_i && (cmd_msg_type_i == e_cmd_sync ||
                      cmd_msg_type_i == e_cmd_invalidate_tag)) begin
        check("consumed with ack", resp_v_o & resp_yumi_i, cmd_yumi_o);
      end
      if (tr_open) begin
        check("tr_v held", 1, tr_v_o);
      end
      if (tr_v_o & tr_ready_i) begin
        tr_cnt++;
        tr_open = 1'b0;
        check("tr block", block_at(index_of(cmd_addr_i), cmd_way_id_i), tr_data_o);
        check("tr dst", cmd_target_i, tr_dst_id_o);
        check("tr way", cmd_target_way_id_i, tr_way_id_o);
        check("tr src", id_i, tr_src_id_o);
        check("tr addr", cmd_addr_i, tr_addr_o);
      end
      if (data_mem_v_o & data_mem_yumi_i) begin
        tr_open = 1'b1;
        check("read index", index_of(cmd_addr_i), data_mem_index_o);
        check("read way", cmd_way_id_i, data_mem_way_o);
      end
      set_cnt  += tag_set_o;
      wake_cnt += tag_set_wakeup_o;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= max_cycles_lp) begin
      $display("timeout: the run hung after %0d cycles in test %s", cycles, test_name);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic send_cmd(input cmd_msg_e msg, input logic [cce_id_width_lp-1:0] src,
                          input logic [addr_width_lp-1:0] addr,
                          input logic [way_width_lp-1:0] way, input coh_state_e state);
    cmd_v_i             <= 1'b1;
    cmd_msg_type_i      <= msg;
    cmd_src_id_i        <= src;
    cmd_addr_i          <= addr;
    cmd_way_id_i        <= way;
    cmd_state_i         <= state;
    cmd_target_i        <= lce_id_width_lp'($urandom);
    cmd_target_way_id_i <= way_width_lp'($urandom);
    do @(posedge clk_i); while (!cmd_yumi_o);
    cmd_v_i <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic start_test(input string name, input logic stall);
    test_name    = name;
    stall_en    <= stall;
    err_at_start = errors;
    tag_cnt      = 0;
    meta_cnt     = 0;
    resp_cnt     = 0;
    tr_cnt       = 0;
    set_cnt      = 0;
    wake_cnt     = 0;
    repeat (2) @(posedge clk_i);
  endtask

  task automatic finish_test();
    tests++;
    $display("test %s finished, %0d errors", test_name, errors - err_at_start);
  endtask

  initial begin
    void'($urandom(42726));
    reset_i             = 1'b1;
    id_i                = own_id_lp;
    cmd_v_i             = 1'b0;
    cmd_msg_type_i      = e_cmd_set_clear;
    cmd_src_id_i        = '0;
    cmd_addr_i          = '0;
    cmd_way_id_i        = '0;
    cmd_state_i         = e_coh_i;
    cmd_target_i        = '0;
    cmd_target_way_id_i = '0;
    data_mem_data_i     = '0;
    tr_ready_i          = 1'b0;
    {tag_rdy, meta_rdy, data_rdy, resp_rdy} = 4'hf;
    stall_en  = 1'b0;
    ready_exp = 1'b0;
    tr_open   = 1'b0;
    {errors, checks, tests, sync_cnt} = '0;
    test_name = "reset";
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    // both memories accept together during set-clear
    start_test("set_clear", 1'b0);
    send_cmd(e_cmd_set_clear, 1'b0, addr_width_lp'($urandom), 3'd5, e_coh_m);
    check("tag requests", 1, tag_cnt);
    check("meta requests", 1, meta_cnt);
    finish_test();

    start_test("sync", 1'b1);
    for (int i = 0; i < num_cce_lp; i++) begin
      check("ready before last sync", 0, lce_ready_o);
      send_cmd(e_cmd_sync, cce_id_width_lp'(i), addr_width_lp'($urandom), 3'd0, e_coh_i);
    end
    check("sync acks", num_cce_lp, resp_cnt);
    check("ready after sync", 1, lce_ready_o);
    finish_test();

    start_test("set_tag", 1'b1);
    repeat (3) begin
      send_cmd(e_cmd_set_tag, 1'b0, addr_width_lp'($urandom), way_width_lp'($urandom),
               coh_state_e'($urandom % 4));
      send_cmd(e_cmd_set_tag_wakeup, 1'b1, addr_width_lp'($urandom), way_width_lp'($urandom),
               coh_state_e'($urandom % 4));
    end
    check("tag requests", 6, tag_cnt);
    check("tag_set pulses", 3, set_cnt);
    check("wakeup pulses", 3, wake_cnt);
    finish_test();

    start_test("invalidate", 1'b1);
    repeat (4) begin
      tag_cnt  = 0;
      meta_cnt = 0;
      resp_cnt = 0;
      send_cmd(e_cmd_invalidate_tag, cce_id_width_lp'($urandom), addr_width_lp'($urandom),
               way_width_lp'($urandom), e_coh_s);
      check("tag invalidates", 1, tag_cnt);
      check("lru updates", 1, meta_cnt);
      check("inv acks", 1, resp_cnt);
    end
    finish_test();

    start_test("transfer", 1'b1);
    repeat (4) begin
      tr_cnt = 0;
      send_cmd(e_cmd_transfer, 1'b0, addr_width_lp'($urandom), way_width_lp'($urandom), e_coh_e);
      check("transfers", 1, tr_cnt);
    end
    finish_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: lce_cmd_top.sv
/*
  LCE command side top level
  Joins the command controller with the memory request former,
  the directory response former and the transfer buffer.
*/

`timescale 1ns/1ps

module lce_cmd_top import lce_cmd_pkg::*; (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [lce_id_width_lp-1:0] id_i,

  output logic                       lce_ready_o,
  output logic                       tag_set_o,
  output logic                       tag_set_wakeup_o,

  // command from a directory
  input  logic                       cmd_v_i,
  input  cmd_msg_e                   cmd_msg_type_i,
  input  logic [cce_id_width_lp-1:0] cmd_src_id_i,
  input  logic [addr_width_lp-1:0]   cmd_addr_i,
  input  logic [way_width_lp-1:0]    cmd_way_id_i,
  input  coh_state_e                 cmd_state_i,
  input  logic [lce_id_width_lp-1:0] cmd_target_i,
  input  logic [way_width_lp-1:0]    cmd_target_way_id_i,
  output logic                       cmd_yumi_o,

  output logic                       tag_mem_v_o,
  output logic [index_width_lp-1:0]  tag_mem_index_o,
  output logic [way_width_lp-1:0]    tag_mem_way_o,
  output coh_state_e                 tag_mem_state_o,
  output logic [tag_width_lp-1:0]    tag_mem_tag_o,
  output tag_op_e                    tag_mem_opcode_o,
  input  logic                       tag_mem_yumi_i,

  output logic                       meta_mem_v_o,
  output logic [index_width_lp-1:0]  meta_mem_index_o,
  output logic [way_width_lp-1:0]    meta_mem_way_o,
  output meta_op_e                   meta_mem_opcode_o,
  input  logic                       meta_mem_yumi_i,

  output logic                       data_mem_v_o,
  output logic [index_width_lp-1:0]  data_mem_index_o,
  output logic [way_width_lp-1:0]    data_mem_way_o,
  input  logic                       data_mem_yumi_i,
  input  logic [data_width_lp-1:0]   data_mem_data_i,

  // response to a directory
  output logic                       resp_v_o,
  output logic [lce_id_width_lp-1:0] resp_src_id_o,
  output logic [cce_id_width_lp-1:0] resp_dst_id_o,
  output logic [addr_width_lp-1:0]   resp_addr_o,
  output resp_msg_e                  resp_msg_type_o,
  input  logic                       resp_yumi_i,

  // transfer to another agent
  output logic                       tr_v_o,
  output logic [lce_id_width_lp-1:0] tr_dst_id_o,
  output logic [lce_id_width_lp-1:0] tr_src_id_o,
  output logic [way_width_lp-1:0]    tr_way_id_o,
  output logic [addr_width_lp-1:0]   tr_addr_o,
  output logic [data_width_lp-1:0]   tr_data_o,
  input  logic                       tr_ready_i
);

  tag_op_e   tag_op;
  meta_op_e  meta_op;
  resp_msg_e resp_msg;
  logic      tr_first;

  lce_cmd_ctrl lce_cmd_ctrl_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .cmd_v_i          (cmd_v_i),
    .cmd_msg_type_i   (cmd_msg_type_i),
    .cmd_yumi_o       (cmd_yumi_o),
    .tag_mem_v_o      (tag_mem_v_o),
    .tag_op_o         (tag_op),
    .tag_mem_yumi_i   (tag_mem_yumi_i),
    .meta_mem_v_o     (meta_mem_v_o),
    .meta_op_o        (meta_op),
    .meta_mem_yumi_i  (meta_mem_yumi_i),
    .data_mem_v_o     (data_mem_v_o),
    .data_mem_yumi_i  (data_mem_yumi_i),
    .resp_v_o         (resp_v_o),
    .resp_msg_o       (resp_msg),
    .resp_yumi_i      (resp_yumi_i),
    .tr_v_o           (tr_v_o),
    .tr_first_o       (tr_first),
    .tr_ready_i       (tr_ready_i),
    .lce_ready_o      (lce_ready_o),
    .tag_set_o        (tag_set_o),
    .tag_set_wakeup_o (tag_set_wakeup_o)
  );

  lce_mem_pkt_gen lce_mem_pkt_gen_inst (
    .cmd_addr_i        (cmd_addr_i),
    .cmd_way_id_i      (cmd_way_id_i),
    .cmd_state_i       (cmd_state_i),
    .tag_op_i          (tag_op),
    .meta_op_i         (meta_op),
    .tag_mem_index_o   (tag_mem_index_o),
    .tag_mem_way_o     (tag_mem_way_o),
    .tag_mem_state_o   (tag_mem_state_o),
    .tag_mem_tag_o     (tag_mem_tag_o),
    .tag_mem_opcode_o  (tag_mem_opcode_o),
    .meta_mem_index_o  (meta_mem_index_o),
    .meta_mem_way_o    (meta_mem_way_o),
    .meta_mem_opcode_o (meta_mem_opcode_o),
    .data_mem_index_o  (data_mem_index_o),
    .data_mem_way_o    (data_mem_way_o)
  );

  lce_resp_gen lce_resp_gen_inst (
    .id_i            (id_i),
    .cmd_src_id_i    (cmd_src_id_i),
    .cmd_addr_i      (cmd_addr_i),
    .resp_msg_i      (resp_msg),
    .resp_src_id_o   (resp_src_id_o),
    .resp_dst_id_o   (resp_dst_id_o),
    .resp_addr_o     (resp_addr_o),
    .resp_msg_type_o (resp_msg_type_o)
  );

  lce_tr_buffer lce_tr_buffer_inst (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .id_i                (id_i),
    .tr_v_i              (tr_v_o),
    .tr_first_i          (tr_first),
    .tr_ready_i          (tr_ready_i),
    .cmd_target_i        (cmd_target_i),
    .cmd_target_way_id_i (cmd_target_way_id_i),
    .cmd_addr_i          (cmd_addr_i),
    .data_mem_data_i     (data_mem_data_i),
    .tr_dst_id_o         (tr_dst_id_o),
    .tr_src_id_o         (tr_src_id_o),
    .tr_way_id_o         (tr_way_id_o),
    .tr_addr_o           (tr_addr_o),
    .tr_data_o           (tr_data_o)
  );

endmodule

// File: lce_tr_buffer.sv
/*
  LCE transfer buffer
  Keeps the block read for a cache-to-cache transfer while the
  receiving agent stalls, and forms the transfer response fields.
*/

`timescale 1ns/1ps

module lce_tr_buffer import lce_cmd_pkg::*; (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [lce_id_width_lp-1:0] id_i,

  input  logic                       tr_v_i,
  input  logic                       tr_first_i,
  input  logic                       tr_ready_i,

  input  logic [lce_id_width_lp-1:0] cmd_target_i,
  input  logic [way_width_lp-1:0]    cmd_target_way_id_i,
  input  logic [addr_width_lp-1:0]   cmd_addr_i,
  input  logic [data_width_lp-1:0]   data_mem_data_i,

  output logic [lce_id_width_lp-1:0] tr_dst_id_o,
  output logic [lce_id_width_lp-1:0] tr_src_id_o,
  output logic [way_width_lp-1:0]    tr_way_id_o,
  output logic [addr_width_lp-1:0]   tr_addr_o,
  output logic [data_width_lp-1:0]   tr_data_o
);

  logic [data_width_lp-1:0] data_r;
  logic                     buffered_r;
  logic                     capture;

  // read data is only live in the first cycle
  assign capture = tr_v_i & tr_first_i & ~tr_ready_i;

  always_ff @(posedge clk_i) begin
    if (capture) begin
      data_r <= data_mem_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      buffered_r <= 1'b0;
    end else if (tr_v_i & tr_ready_i) begin
      buffered_r <= 1'b0;
    end else if (capture) begin
      buffered_r <= 1'b1;
    end
  end

  assign tr_dst_id_o = cmd_target_i;
  assign tr_src_id_o = id_i;
  assign tr_way_id_o = cmd_target_way_id_i;
  assign tr_addr_o   = cmd_addr_i;
  assign tr_data_o   = buffered_r ? data_r : data_mem_data_i;

endmodule

// File: lce_resp_gen.sv
/*
  LCE coherence response former
  Addresses sync and invalidate acknowledgements back to the
  directory that issued the command.
*/

`timescale 1ns/1ps

module lce_resp_gen import lce_cmd_pkg::*; (
  input  logic [lce_id_width_lp-1:0] id_i,
  input  logic [cce_id_width_lp-1:0] cmd_src_id_i,
  input  logic [addr_width_lp-1:0]   cmd_addr_i,
  input  resp_msg_e                  resp_msg_i,

  output logic [lce_id_width_lp-1:0] resp_src_id_o,
  output logic [cce_id_width_lp-1:0] resp_dst_id_o,
  output logic [addr_width_lp-1:0]   resp_addr_o,
  output resp_msg_e                  resp_msg_type_o
);

  assign resp_src_id_o   = id_i;
  assign resp_dst_id_o   = cmd_src_id_i;
  assign resp_msg_type_o = resp_msg_i;

  // sync_ack carries no address
  assign resp_addr_o = (resp_msg_i == e_resp_inv_ack) ? cmd_addr_i : '0;

endmodule

// File: lce_mem_pkt_gen.sv
/*
  LCE memory request former
  Builds the tag, metadata and data memory request fields from the
  current command and the opcodes chosen by the controller.
*/

`timescale 1ns/1ps

module lce_mem_pkt_gen import lce_cmd_pkg::*; (
  input  logic [addr_width_lp-1:0]  cmd_addr_i,
  input  logic [way_width_lp-1:0]   cmd_way_id_i,
  input  coh_state_e                cmd_state_i,
  input  tag_op_e                   tag_op_i,
  input  meta_op_e                  meta_op_i,

  output logic [index_width_lp-1:0] tag_mem_index_o,
  output logic [way_width_lp-1:0]   tag_mem_way_o,
  output coh_state_e                tag_mem_state_o,
  output logic [tag_width_lp-1:0]   tag_mem_tag_o,
  output tag_op_e                   tag_mem_opcode_o,

  output logic [index_width_lp-1:0] meta_mem_index_o,
  output logic [way_width_lp-1:0]   meta_mem_way_o,
  output meta_op_e                  meta_mem_opcode_o,

  output logic [index_width_lp-1:0] data_mem_index_o,
  output logic [way_width_lp-1:0]   data_mem_way_o
);

  logic [index_width_lp-1:0] index;
  logic [tag_width_lp-1:0]   tag;
  logic                      clears_line;

  assign index = cmd_addr_i[offset_width_lp +: index_width_lp];
  assign tag   = cmd_addr_i[tag_offset_lp +: tag_width_lp];

  // set-clear and invalidate both leave the line invalid
  assign clears_line = (tag_op_i == e_tag_set_clear) | (tag_op_i == e_tag_invalidate);

  assign tag_mem_index_o  = index;
  assign tag_mem_way_o    = cmd_way_id_i;
  assign tag_mem_state_o  = clears_line ? e_coh_i : cmd_state_i;
  assign tag_mem_tag_o    = (tag_op_i == e_tag_set_clear) ? '0 : tag;
  assign tag_mem_opcode_o = tag_op_i;

  assign meta_mem_index_o  = index;
  assign meta_mem_way_o    = cmd_way_id_i;
  assign meta_mem_opcode_o = meta_op_i;

  // read only, block comes back one cycle after yumi
  assign data_mem_index_o = index;
  assign data_mem_way_o   = cmd_way_id_i;

endmodule

// File: lce_cmd_ctrl.sv
/*
  LCE command controller
  Reset/ready/transfer FSM. Counts sync acknowledgements, tracks
  invalidate progress and raises every valid and yumi strobe.
*/

`timescale 1ns/1ps

module lce_cmd_ctrl import lce_cmd_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,

  input  logic       cmd_v_i,
  input  cmd_msg_e   cmd_msg_type_i,
  output logic       cmd_yumi_o,

  output logic       tag_mem_v_o,
  output tag_op_e    tag_op_o,
  input  logic       tag_mem_yumi_i,

  output logic       meta_mem_v_o,
  output meta_op_e   meta_op_o,
  input  logic       meta_mem_yumi_i,

  output logic       data_mem_v_o,
  input  logic       data_mem_yumi_i,

  output logic       resp_v_o,
  output resp_msg_e  resp_msg_o,
  input  logic       resp_yumi_i,

  output logic       tr_v_o,
  output logic       tr_first_o,
  input  logic       tr_ready_i,

  output logic       lce_ready_o,
  output logic       tag_set_o,
  output logic       tag_set_wakeup_o
);

  lce_state_e                   state_r, state_n;
  logic [sync_cnt_width_lp-1:0] sync_cnt_r, sync_cnt_n;
  logic                         inv_tag_r, inv_tag_n;
  logic                         inv_lru_r, inv_lru_n;
  logic                         tr_first_r;
  logic                         inv_tag_done;
  logic                         inv_lru_done;

  // write taken now or in an earlier cycle
  assign inv_tag_done = inv_tag_r | tag_mem_yumi_i;
  assign inv_lru_done = inv_lru_r | meta_mem_yumi_i;

  assign lce_ready_o = (state_r != e_state_reset);
  assign tr_first_o  = tr_first_r;

  always_comb begin
    cmd_yumi_o       = 1'b0;
    tag_mem_v_o      = 1'b0;
    tag_op_o         = e_tag_set_clear;
    meta_mem_v_o     = 1'b0;
    meta_op_o        = e_meta_set_clear;
    data_mem_v_o     = 1'b0;
    resp_v_o         = 1'b0;
    resp_msg_o       = e_resp_sync_ack;
    tr_v_o           = 1'b0;
    tag_set_o        = 1'b0;
    tag_set_wakeup_o = 1'b0;

    state_n    = state_r;
    sync_cnt_n = sync_cnt_r;
    inv_tag_n  = inv_tag_r;
    inv_lru_n  = inv_lru_r;

    case (state_r)
      e_state_reset: begin
        if (cmd_v_i) begin
          case (cmd_msg_type_i)
            e_cmd_set_clear: begin
              tag_mem_v_o  = 1'b1;
              tag_op_o     = e_tag_set_clear;
              meta_mem_v_o = 1'b1;
              meta_op_o    = e_meta_set_clear;
              cmd_yumi_o   = tag_mem_yumi_i;
            end
            e_cmd_sync: begin
              resp_v_o   = 1'b1;
              resp_msg_o = e_resp_sync_ack;
              cmd_yumi_o = resp_yumi_i;
              if (resp_yumi_i) begin
                sync_cnt_n = sync_cnt_r + 1'b1;
                // last directory acknowledged
                if (sync_cnt_r == sync_cnt_width_lp'(num_cce_lp - 1)) begin
                  state_n = e_state_ready;
                end
              end
            end
            default: ;
          endcase
        end
      end

      e_state_ready: begin
        if (cmd_v_i) begin
          case (cmd_msg_type_i)
            e_cmd_set_tag: begin
              tag_mem_v_o = 1'b1;
              tag_op_o    = e_tag_set_tag;
              cmd_yumi_o  = tag_mem_yumi_i;
              tag_set_o   = tag_mem_yumi_i;
            end
            e_cmd_set_tag_wakeup: begin
              tag_mem_v_o      = 1'b1;
              tag_op_o         = e_tag_set_tag;
              cmd_yumi_o       = tag_mem_yumi_i;
              tag_set_wakeup_o = tag_mem_yumi_i;
            end
            e_cmd_invalidate_tag: begin
              // tag write, then lru update, then inv_ack
              tag_mem_v_o  = ~inv_tag_r;
              tag_op_o     = e_tag_invalidate;
              meta_mem_v_o = ~inv_lru_r & inv_tag_done;
              meta_op_o    = e_meta_set_lru;
              resp_v_o     = inv_tag_done & inv_lru_done;
              resp_msg_o   = e_resp_inv_ack;
              cmd_yumi_o   = resp_yumi_i;
              inv_tag_n    = resp_yumi_i ? 1'b0 : inv_tag_done;
              inv_lru_n    = resp_yumi_i ? 1'b0 : inv_lru_done;
            end
            e_cmd_transfer: begin
              data_mem_v_o = 1'b1;
              if (data_mem_yumi_i) begin
                state_n = e_state_transfer;
              end
            end
            default: ;
          endcase
        end
      end

      e_state_transfer: begin
        tr_v_o     = 1'b1;
        cmd_yumi_o = tr_ready_i;
        if (tr_ready_i) begin
          state_n = e_state_ready;
        end
      end

      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= e_state_reset;
      sync_cnt_r <= '0;
      inv_tag_r  <= 1'b0;
      inv_lru_r  <= 1'b0;
      tr_first_r <= 1'b0;
    end else begin
      state_r    <= state_n;
      sync_cnt_r <= sync_cnt_n;
      inv_tag_r  <= inv_tag_n;
      inv_lru_r  <= inv_lru_n;
      // block arrives in the first transfer cycle
      tr_first_r <= (state_r == e_state_ready) & (state_n == e_state_transfer);
    end
  end

endmodule

// File: lce_cmd_pkg.sv
/*
  LCE command side shared definitions
  Address layout, field widths, message codes, memory opcodes
  and the command FSM states used by every block of the agent.
*/

package lce_cmd_pkg;

  // address and cache geometry
  localparam int addr_width_lp   = 22;
  localparam int offset_width_lp = 6;
  localparam int index_width_lp  = 6;
  localparam int tag_width_lp    = addr_width_lp - offset_width_lp - index_width_lp;
  localparam int way_width_lp    = 3;
  localparam int data_width_lp   = 64;

  // bit position of the tag in the address
  localparam int tag_offset_lp = offset_width_lp + index_width_lp;

  // agent and directory ids
  localparam int lce_id_width_lp = 2;
  localparam int cce_id_width_lp = 1;
  localparam int num_cce_lp      = 2;

  localparam int sync_cnt_width_lp = (num_cce_lp > 1) ? $clog2(num_cce_lp) : 1;

  typedef enum logic [2:0] {
    e_cmd_set_clear      = 3'd0,
    e_cmd_sync           = 3'd1,
    e_cmd_set_tag        = 3'd2,
    e_cmd_set_tag_wakeup = 3'd3,
    e_cmd_invalidate_tag = 3'd4,
    e_cmd_transfer       = 3'd5
  } cmd_msg_e;

  typedef enum logic {
    e_resp_sync_ack = 1'b0,
    e_resp_inv_ack  = 1'b1
  } resp_msg_e;

  typedef enum logic [1:0] {
    e_tag_set_clear  = 2'd0,
    e_tag_set_tag    = 2'd1,
    e_tag_invalidate = 2'd2
  } tag_op_e;

  typedef enum logic {
    e_meta_set_clear = 1'b0,
    e_meta_set_lru   = 1'b1
  } meta_op_e;

  // invalid must stay at zero
  typedef enum logic [1:0] {
    e_coh_i = 2'd0,
    e_coh_s = 2'd1,
    e_coh_e = 2'd2,
    e_coh_m = 2'd3
  } coh_state_e;

  typedef enum logic [1:0] {
    e_state_reset    = 2'd0,
    e_state_ready    = 2'd1,
    e_state_transfer = 2'd2
  } lce_state_e;

endpackage
